// File: src/lsu_pkg.sv
package lsu_pkg;

  // Core data path and address width
  localparam int XLEN = 32;

  // One enable bit per byte lane
  localparam int MASK_W = XLEN / 8;

  localparam int OP_W    = 3;  // Opcode field width
  localparam int STATE_W = 2;  // Controller state width

  // Load and store operations presented by the pipeline
  typedef enum logic [OP_W-1:0] {
    LSU_LB  = 3'd0,
    LSU_LH  = 3'd1,
    LSU_LW  = 3'd2,
    LSU_LBU = 3'd3,
    LSU_LHU = 3'd4,
    LSU_SB  = 3'd5,
    LSU_SH  = 3'd6,
    LSU_SW  = 3'd7
  } lsu_op_e;

  // Controller sequence
  typedef enum logic [STATE_W-1:0] {
    ST_IDLE   = 2'd0,  // Waiting for a request
    ST_ACCESS = 2'd1,  // Strobes presented to memory
    ST_WAIT   = 2'd2,  // Memory wait cycles
    ST_DONE   = 2'd3   // Result returned
  } lsu_state_e;

endpackage

// File: src/dmem_if.sv
`timescale 1ns/1ps

interface dmem_if;
  import lsu_pkg::*;

  logic              cs;       // Chip select, active low
  logic              wr;       // Write strobe, active low
  logic [MASK_W-1:0] mask;     // Byte lane enables
  logic [XLEN-1:0]   addr;     // Byte address
  logic [XLEN-1:0]   data_wr;  // Store data, already lane aligned
  logic [XLEN-1:0]   data_rd;  // Read word

  // Requesting side
  modport ctrl (
    output cs, wr, mask, addr, data_wr,
    input  data_rd
  );

  // Memory side
  modport mem (
    input  cs, wr, mask, addr, data_wr,
    output data_rd
  );

endinterface

// File: src/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl #(
  parameter int WAIT_CYCLES = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req,
  input  lsu_pkg::lsu_op_e           op,
  input  logic [lsu_pkg::XLEN-1:0]   addr,
  input  logic [lsu_pkg::XLEN-1:0]   wdata,
  input  logic [lsu_pkg::MASK_W-1:0] st_mask,
  input  logic [lsu_pkg::XLEN-1:0]   st_data,
  input  logic                       misaligned,
  input  logic                       expired,
  output logic                       timer_start,
  output logic                       load_en,
  output lsu_pkg::lsu_op_e           op_q,
  output logic [lsu_pkg::XLEN-1:0]   addr_q,
  output logic [lsu_pkg::XLEN-1:0]   wdata_q,
  output logic                       busy,
  output logic                       done,
  output logic                       err,
  dmem_if.ctrl                       mem
);
  import lsu_pkg::*;

  lsu_state_e state_q;
  lsu_state_e state_d;
  logic       accept;
  logic       is_store;
  logic       err_q;

  assign busy     = (state_q != ST_IDLE);
  assign accept   = req && !busy;  // New requests only when idle
  assign is_store = op_q inside {LSU_SB, LSU_SH, LSU_SW};

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:   if (accept) state_d = ST_ACCESS;
      ST_ACCESS: state_d = misaligned ? ST_DONE : ST_WAIT;
      ST_WAIT:   if (expired) state_d = ST_DONE;
      ST_DONE:   state_d = ST_IDLE;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= (state_q == ST_ACCESS) && misaligned;  // Only seen in ST_DONE
    end
  end

  // Request held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q    <= op;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  assign timer_start = (state_q == ST_ACCESS) && !misaligned;
  // Capture while the read word is still driven, lands as ST_DONE begins
  assign load_en     = (state_q == ST_WAIT) && expired && !is_store;
  assign done        = (state_q == ST_DONE);
  assign err         = err_q;

  // Misaligned requests never reach the memory
  assign mem.cs      = !(((state_q == ST_ACCESS) && !misaligned) || (state_q == ST_WAIT));
  assign mem.wr      = !((state_q == ST_ACCESS) && !misaligned && is_store);
  assign mem.mask    = st_mask;
  assign mem.addr    = addr_q;
  assign mem.data_wr = st_data;

  a_done_single: assert property (@(posedge clk) disable iff (rst_n)
    done |=> !done);

  a_cs_window: assert property (@(posedge clk) disable iff (rst_n)
    !mem.cs |-> (state_q inside {ST_ACCESS, ST_WAIT}));

  // Timer and FSM together fix the aligned latency
  a_wait_span: assert property (@(posedge clk) disable iff (rst_n)
    timer_start |-> ##(WAIT_CYCLES + 2) done);

endmodule

// File: src/wait_timer.sv
`timescale 1ns/1ps

module wait_timer #(
  parameter int WAIT_CYCLES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic timer_start,
  output logic expired
);
  import lsu_pkg::*;

  localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      count_q <= '0;
    end else if (timer_start) begin
      count_q <= CNT_W'(WAIT_CYCLES);  // Reload
    end else if (count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // Stays high at zero until the next start
  assign expired = (count_q == '0);

  // The controller must not restart a running count
  a_no_restart: assert property (@(posedge clk) disable iff (rst_n)
    timer_start |-> (count_q == '0));

endmodule

// File: src/store_format.sv
`timescale 1ns/1ps

module store_format (
  input  lsu_pkg::lsu_op_e           op,
  input  logic [lsu_pkg::XLEN-1:0]   addr,
  input  logic [lsu_pkg::XLEN-1:0]   wdata,
  output logic [lsu_pkg::MASK_W-1:0] st_mask,
  output logic [lsu_pkg::XLEN-1:0]   st_data,
  output logic                       misaligned
);
  import lsu_pkg::*;

  logic              is_half;
  logic              is_word;
  logic              is_store;
  logic [MASK_W-1:0] lane_mask;

  assign is_half  = op inside {LSU_LH, LSU_LHU, LSU_SH};
  assign is_word  = op inside {LSU_LW, LSU_SW};
  assign is_store = op inside {LSU_SB, LSU_SH, LSU_SW};

  assign misaligned = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

  always_comb begin
    if (is_word) begin
      lane_mask = '1;
      st_data   = wdata;
    end else if (is_half) begin
      lane_mask = MASK_W'(4'b0011) << addr[1:0];
      st_data   = {2{wdata[15:0]}};  // Halfword in both halves
    end else begin
      lane_mask = MASK_W'(4'b0001) << addr[1:0];
      st_data   = {4{wdata[7:0]}};   // Byte in every lane
    end
  end

  // No lanes enabled for loads
  assign st_mask = is_store ? lane_mask : '0;

endmodule

// File: src/load_format.sv
`timescale 1ns/1ps

module load_format (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     load_en,
  input  lsu_pkg::lsu_op_e         op,
  input  logic [1:0]               byte_off,
  input  logic [lsu_pkg::XLEN-1:0] data_rd,
  output logic [lsu_pkg::XLEN-1:0] rdata
);
  import lsu_pkg::*;

  logic [XLEN-1:0] lane_word;
  logic [7:0]      ld_byte;
  logic [15:0]     ld_half;
  logic [XLEN-1:0] ext;
  logic [XLEN-1:0] rdata_q;

  // Addressed byte moved down to lane 0
  assign lane_word = data_rd >> {byte_off, 3'b000};
  assign ld_byte   = lane_word[7:0];
  assign ld_half   = lane_word[15:0];

  always_comb begin
    case (op)
      LSU_LB:  ext = {{(XLEN-8){ld_byte[7]}}, ld_byte};
      LSU_LH:  ext = {{(XLEN-16){ld_half[15]}}, ld_half};
      LSU_LBU: ext = {{(XLEN-8){1'b0}}, ld_byte};
      LSU_LHU: ext = {{(XLEN-16){1'b0}}, ld_half};
      default: ext = data_rd;  // LW
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rdata_q <= '0;
    end else if (load_en) begin
      rdata_q <= ext;  // Held until the next load
    end
  end

  assign rdata = rdata_q;

endmodule

// File: src/dmem.sv
`timescale 1ns/1ps

module dmem #(
  parameter int DMEM_WORDS = 256
) (
  input  logic clk,
  input  logic rst_n,
  dmem_if.mem  mem
);
  import lsu_pkg::*;

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]   ram [DMEM_WORDS] = '{default: '0};
  logic              cs_q;
  logic              wr_q;
  logic [MASK_W-1:0] mask_q;
  logic [IDX_W-1:0]  idx_q;
  logic [XLEN-1:0]   data_wr_q;

  // Request sampled mid-cycle on the falling edge
  always_ff @(negedge clk) begin
    if (rst_n) begin
      cs_q      <= 1'b1;
      wr_q      <= 1'b1;
      mask_q    <= '0;
      idx_q     <= '0;
      data_wr_q <= '0;
    end else begin
      cs_q      <= mem.cs;
      wr_q      <= mem.wr;
      mask_q    <= mem.mask;
      idx_q     <= mem.addr[IDX_W+1:2];  // Word index
      data_wr_q <= mem.data_wr;
    end
  end

  // Latched write lands one falling edge later
  always_ff @(negedge clk) begin
    if (!cs_q && !wr_q) begin
      for (int i = 0; i < MASK_W; i++) begin
        if (mask_q[i]) ram[idx_q][8*i +: 8] <= data_wr_q[8*i +: 8];
      end
    end
  end

  assign mem.data_rd = mem.cs ? '0 : ram[idx_q];  // Asynchronous read

  a_write_mask: assert property (@(negedge clk) disable iff (rst_n)
    (!cs_q && !wr_q) |-> (mask_q != '0));

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  parameter int DMEM_WORDS  = 256,
  parameter int WAIT_CYCLES = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req,
  input  lsu_pkg::lsu_op_e op,
  input  logic [31:0]      addr,
  input  logic [31:0]      wdata,
  output logic             busy,
  output logic             done,
  output logic             err,
  output logic [31:0]      rdata
);
  import lsu_pkg::*;

  logic [MASK_W-1:0] st_mask;
  logic [XLEN-1:0]   st_data;
  logic              misaligned;
  logic              expired;
  logic              timer_start;
  logic              load_en;
  lsu_op_e           op_q;
  logic [XLEN-1:0]   addr_q;
  logic [XLEN-1:0]   wdata_q;

  dmem_if i_dmem_if ();

  lsu_ctrl #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .op          (op),
    .addr        (addr),
    .wdata       (wdata),
    .st_mask     (st_mask),
    .st_data     (st_data),
    .misaligned  (misaligned),
    .expired     (expired),
    .timer_start (timer_start),
    .load_en     (load_en),
    .op_q        (op_q),
    .addr_q      (addr_q),
    .wdata_q     (wdata_q),
    .busy        (busy),
    .done        (done),
    .err         (err),
    .mem         (i_dmem_if.ctrl)
  );

  wait_timer #(
    .WAIT_CYCLES (WAIT_CYCLES)
  ) i_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .timer_start (timer_start),
    .expired     (expired)
  );

  // Formatting works on the held request
  store_format i_store_fmt (
    .op         (op_q),
    .addr       (addr_q),
    .wdata      (wdata_q),
    .st_mask    (st_mask),
    .st_data    (st_data),
    .misaligned (misaligned)
  );

  load_format i_load_fmt (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_en  (load_en),
    .op       (op_q),
    .byte_off (addr_q[1:0]),
    .data_rd  (i_dmem_if.data_rd),
    .rdata    (rdata)
  );

  dmem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) i_dmem (
    .clk   (clk),
    .rst_n (rst_n),
    .mem   (i_dmem_if.mem)
  );

endmodule

// File: tests/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
  import lsu_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int WAIT_CYCLES = 2;
  localparam int N_DIRECTED  = 29;   // Directed requests before the random mix
  localparam int N_RANDOM    = 200;
  localparam int N_REQ       = N_DIRECTED + N_RANDOM;
  localparam int WATCHDOG_NS = (N_REQ * (WAIT_CYCLES + 4) + 100) * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req;
  lsu_op_e     op;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        busy;
  logic        done;
  logic        err;
  logic [31:0] rdata;

  logic [31:0] model [256];
  logic [31:0] exp_data;
  logic        exp_err;
  logic [31:0] rnd;
  integer      seed;
  int          exp_lat;
  int          cycle_cnt = 0;
  int          accept_cycle = 0;
  int          n_acc = 0;
  int          n_done = 0;

  lsu_top #(
    .DMEM_WORDS  (256),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .op    (op),
    .addr  (addr),
    .wdata (wdata),
    .busy  (busy),
    .done  (done),
    .err   (err),
    .rdata (rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("sim failed");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("sim failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      $display("sim failed");
      $fatal(1, "latency mismatch");
    end
  endtask

  // Expected result from the load/store rules; stores and errors keep prev_rd
  function automatic void ref_access(input lsu_op_e f_op, input logic [31:0] f_addr,
      input logic [31:0] f_wdata, input logic [31:0] prev_rd, ref logic [31:0] mem_model [256],
      output logic [31:0] exp_rd, output logic exp_err_o);
    int          size;
    int          off;
    logic [7:0]  idx;
    logic [31:0] val;
    size = 1;
    if (f_op inside {LSU_LH, LSU_LHU, LSU_SH}) size = 2;
    if (f_op inside {LSU_LW, LSU_SW}) size = 4;
    off       = int'(f_addr[1:0]);
    idx       = f_addr[9:2];
    exp_rd    = prev_rd;
    exp_err_o = (off % size) != 0;
    if (!exp_err_o && f_op inside {LSU_SB, LSU_SH, LSU_SW}) begin
      for (int i = 0; i < size; i++) begin
        mem_model[idx][8*(off+i) +: 8] = f_wdata[8*i +: 8];
      end
    end else if (!exp_err_o) begin
      val = '0;
      for (int i = 0; i < size; i++) begin
        val[8*i +: 8] = mem_model[idx][8*(off+i) +: 8];
      end
      if (f_op inside {LSU_LB, LSU_LH} && val[8*size-1]) begin
        for (int i = size; i < 4; i++) begin
          val[8*i +: 8] = 8'hFF;  // Sign fill
        end
      end
      exp_rd = val;
    end
  endfunction

  // One request; optionally pokes a second store while the first is busy
  task automatic do_request(input lsu_op_e r_op, input logic [31:0] r_addr,
      input logic [31:0] r_wdata, input bit poke_busy);
    int          target;
    logic [31:0] new_rd;
    logic        new_err;
    ref_access(r_op, r_addr, r_wdata, exp_data, model, new_rd, new_err);
    @(posedge clk);
    #1;
    req   = 1'b1;
    op    = r_op;
    addr  = r_addr;
    wdata = r_wdata;
    @(posedge clk);
    #1;
    exp_data     = new_rd;
    exp_err      = new_err;
    exp_lat      = new_err ? 1 : WAIT_CYCLES + 2;
    accept_cycle = cycle_cnt;
    target       = n_done + 1;
    n_acc        = n_acc + 1;
    req          = 1'b0;
    if (poke_busy) begin
      if (!busy) begin
        $display("busy was low right after a request was accepted");
        $display("sim failed");
        $fatal(1, "busy low");
      end
      req   = 1'b1;  // Must be ignored
      op    = LSU_SW;
      addr  = r_addr ^ 32'h10;
      wdata = 32'hDEAD_BEEF;
      @(posedge clk);
      #1;
      req = 1'b0;
    end
    wait (n_done == target);
  endtask

  // Results are compared mid-cycle during the done pulse
  always @(negedge clk) begin
    if (!rst_n && done) begin
      if (n_acc <= n_done) begin
        $display("done pulsed with no request outstanding");
        $display("sim failed");
        $fatal(1, "spurious done");
      end else begin
        check_latency("latency", exp_lat, cycle_cnt - accept_cycle);
        check_err("err", exp_err, err);
        check_data("rdata", exp_data, rdata);
        n_done = n_done + 1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: done never came for an outstanding request");
    $display("sim failed");
    $fatal(1, "watchdog");
  end

  initial begin
    rst_n    = 1'b1;
    req      = 1'b0;
    op       = LSU_LB;
    addr     = '0;
    wdata    = '0;
    exp_data = '0;
    exp_err  = 1'b0;
    exp_lat  = 0;
    seed     = 45;
    model    = '{default: '0};
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b0;

    // Word round trip
    do_request(LSU_SW, 32'h00, 32'h0123_4567, 1'b0);
    do_request(LSU_SW, 32'h04, 32'h89AB_CDEF, 1'b0);
    do_request(LSU_SW, 32'h40, 32'hCAFE_F00D, 1'b0);
    do_request(LSU_SW, 32'hFC, 32'h5A5A_A5A5, 1'b0);
    do_request(LSU_LW, 32'h00, 32'h0, 1'b0);
    do_request(LSU_LW, 32'h04, 32'h0, 1'b0);
    do_request(LSU_LW, 32'h40, 32'h0, 1'b0);
    do_request(LSU_LW, 32'hFC, 32'h0, 1'b0);
    do_request(LSU_LW, 32'h80, 32'h0, 1'b0);  // Never written

    // Sub-word merge
    do_request(LSU_SW, 32'h20, 32'h1122_3344, 1'b0);
    do_request(LSU_SB, 32'h21, 32'h0000_00AA, 1'b0);
    do_request(LSU_SH, 32'h22, 32'h0000_BEEF, 1'b0);
    do_request(LSU_SB, 32'h20, 32'hFFFF_FF77, 1'b0);
    do_request(LSU_LW, 32'h20, 32'h0, 1'b0);

    // Load extension
    do_request(LSU_SW, 32'h30, 32'h8091_F2E3, 1'b0);
    do_request(LSU_LB, 32'h30, 32'h0, 1'b0);
    do_request(LSU_LB, 32'h33, 32'h0, 1'b0);
    do_request(LSU_LH, 32'h32, 32'h0, 1'b0);
    do_request(LSU_LBU, 32'h31, 32'h0, 1'b0);
    do_request(LSU_LHU, 32'h30, 32'h0, 1'b0);
    do_request(LSU_LHU, 32'h32, 32'h0, 1'b0);

    // Misalignment keeps memory and rdata
    do_request(LSU_LW, 32'h04, 32'h0, 1'b0);
    do_request(LSU_LH, 32'h05, 32'h0, 1'b0);
    do_request(LSU_SH, 32'h07, 32'hFFFF_FFFF, 1'b0);
    do_request(LSU_LW, 32'h06, 32'h0, 1'b0);
    do_request(LSU_SW, 32'h41, 32'hFFFF_FFFF, 1'b0);
    do_request(LSU_LW, 32'h40, 32'h0, 1'b0);

    // Request while busy is dropped
    do_request(LSU_SW, 32'h50, 32'h7777_1111, 1'b1);
    repeat (4) @(posedge clk);
    do_request(LSU_LW, 32'h40, 32'h0, 1'b0);

    // Random mix in the low 64 words
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd = $random(seed);
      do_request(lsu_op_e'(rnd[10:8]), {24'd0, rnd[7:0]}, $random(seed), 1'b0);
    end

    // Room for a stray done after the last request
    repeat (4) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

// File: build.f
src/lsu_pkg.sv
src/dmem_if.sv
src/lsu_ctrl.sv
src/wait_timer.sv
src/store_format.sv
src/load_format.sv
src/dmem.sv
src/lsu_top.sv
tests/tb_lsu.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu -f build.f -o Vtb_lsu

out=$(./obj_dir/Vtb_lsu 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^sim passed$"; then
  exit 0
fi
exit 1
